/* build.f */
rtl/rom_arb_pkg.sv
rtl/snes_bus_sync.sv
rtl/rom_arbiter.sv
rtl/rom_port.sv
rtl/rom_ctrl_top.sv
dv/rom_ctrl_chk.sv
dv/tb_rom_ctrl.sv

/* dv/rom_ctrl_chk.sv */
`timescale 1ns/10ps

module rom_ctrl_chk #(
  parameter int rom_cycle_len = 7
) (
  input  logic                    CLK2,
  input  logic                    reset,
  input  logic                    alive_edge,
  input  rom_arb_pkg::arb_state_t state,
  input  logic                    rom_we_n,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  logic                    mcu_rdy,
  input  logic                    sa1_rrq,
  input  logic                    sa1_wrq,
  input  logic                    sa1_rdy,
  input  logic                    sa1_reset
);

  import rom_arb_pkg::*;

  // access state holds for the full count and then moves to its end state
  property p_access_len(arb_state_t s, arb_state_t e);
    @(posedge CLK2) disable iff (reset || alive_edge)
      $rose(state == s) |-> (state == s) [*(rom_cycle_len + 1)] ##1 (state == e);
  endproperty

  // --------------------------------------------------
  // ROM write strobe
  // --------------------------------------------------

  a_we_only_in_write: assert property (
    @(posedge CLK2) disable iff (reset)
      !rom_we_n |-> (state == st_mcu_wr || state == st_sa1_wr)
  ) else $error("rom_we_n low outside a write state");

  // --------------------------------------------------
  // ready levels
  // --------------------------------------------------

  a_rdy_after_reset: assert property (
    @(posedge CLK2) reset |=> (mcu_rdy && sa1_rdy)
  ) else $error("ready levels not high after reset");

  a_mcu_rdy_hold: assert property (
    @(posedge CLK2) disable iff (reset)
      (mcu_rdy && !mcu_rrq && !mcu_wrq) |=> mcu_rdy
  ) else $error("mcu_rdy dropped without a strobe");

  a_sa1_rdy_hold: assert property (
    @(posedge CLK2) disable iff (reset)
      (sa1_rdy && !sa1_rrq && !sa1_wrq) |=> sa1_rdy
  ) else $error("sa1_rdy dropped without a strobe");

  // --------------------------------------------------
  // access length
  // --------------------------------------------------

  a_len_mcu_rd: assert property (p_access_len(st_mcu_rd, st_mcu_rd_end))
    else $error("MCU read access has the wrong length");
  a_len_mcu_wr: assert property (p_access_len(st_mcu_wr, st_mcu_wr_end))
    else $error("MCU write access has the wrong length");
  a_len_sa1_rd: assert property (p_access_len(st_sa1_rd, st_sa1_rd_end))
    else $error("SA1 read access has the wrong length");
  a_len_sa1_wr: assert property (p_access_len(st_sa1_wr, st_sa1_wr_end))
    else $error("SA1 write access has the wrong length");

  // restart is a lone pulse
  a_restart_single: assert property (
    @(posedge CLK2) disable iff (reset)
      sa1_reset |=> !sa1_reset [*sync_depth]
  ) else $error("sa1_reset pulsed twice in a row");

endmodule

// arbiter state and ROM write strobe of every controller
bind rom_ctrl_top rom_ctrl_chk #(
  .rom_cycle_len(rom_cycle_len)
) i_chk (
  .CLK2(CLK2),
  .reset(reset),
  .alive_edge(alive_edge),
  .state(state),
  .rom_we_n(rom_we_n),
  .mcu_rrq(mcu_rrq),
  .mcu_wrq(mcu_wrq),
  .mcu_rdy(mcu_rdy),
  .sa1_rrq(sa1_rrq),
  .sa1_wrq(sa1_wrq),
  .sa1_rdy(sa1_rdy),
  .sa1_reset(sa1_reset)
);

/* dv/tb_rom_ctrl.sv */
`timescale 1ns/10ps

module tb_rom_ctrl;

  import rom_arb_pkg::*;

  localparam int rom_cycle_len   = 7;
  localparam int dead_timeout    = 200;
  localparam int console_half    = 6;
  localparam int n_mcu           = 16;
  localparam int n_sa1           = 8;
  localparam int n_both          = 4;
  localparam int n_live          = 4;
  localparam int n_console_reads = 8;
  localparam int n_requests      = 2 * n_mcu + 3 * n_sa1 + 2 * n_both + 2 * n_live;
  localparam int console_cycles  = 16 + 40 + n_console_reads * 16 + dead_timeout + 400;
  localparam int timeout_cycles  = n_requests * (rom_cycle_len + 2) * 40 + console_cycles;

  localparam int kind_byte = 0;
  localparam int kind_word = 1;
  localparam int kind_addr = 2;

  typedef struct {
    int          kind;
    logic [23:0] exp;
    logic [23:0] act;
    string       what;
  } result_t;

  logic           CLK2;
  logic           reset;
  snes_addr_t     snes_addr;
  logic           snes_rd_n;
  logic           snes_romsel_n;
  logic           snes_cpu_clk;
  byte_t          snes_rdata;
  logic           mcu_rrq;
  logic           mcu_wrq;
  snes_addr_t     mcu_addr;
  byte_t          mcu_wdata;
  logic           mcu_rdy;
  byte_t          mcu_rdata;
  logic           sa1_rrq;
  logic           sa1_wrq;
  snes_addr_t     sa1_addr;
  logic           sa1_word;
  rom_word_t      sa1_wdata;
  logic           sa1_rdy;
  rom_word_t      sa1_rdata;
  logic           sa1_reset;
  rom_word_addr_t rom_addr;
  logic           rom_bhe_n;
  logic           rom_ble_n;
  logic           rom_we_n;
  rom_word_t      rom_wdata;
  logic           rom_wdata_oe;
  rom_word_t      rom_rdata;

  rom_word_t   mem [0:2047];
  byte_t       shadow [0:4095];
  snes_addr_t  last_wr_addr;
  result_t     results [$];
  logic [31:0] lcg_state;
  logic        console_run;
  int          n_pushed;
  int          n_checked;
  int          err_count;
  int          restart_pulses;

  rom_ctrl_top #(
    .rom_cycle_len(rom_cycle_len),
    .dead_timeout(dead_timeout)
  ) i_dut (
    .CLK2(CLK2), .reset(reset),
    .snes_addr(snes_addr), .snes_rd_n(snes_rd_n), .snes_romsel_n(snes_romsel_n),
    .snes_cpu_clk(snes_cpu_clk), .snes_rdata(snes_rdata),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
    .mcu_rdy(mcu_rdy), .mcu_rdata(mcu_rdata),
    .sa1_rrq(sa1_rrq), .sa1_wrq(sa1_wrq), .sa1_addr(sa1_addr), .sa1_word(sa1_word),
    .sa1_wdata(sa1_wdata), .sa1_rdy(sa1_rdy), .sa1_rdata(sa1_rdata), .sa1_reset(sa1_reset),
    .rom_addr(rom_addr), .rom_bhe_n(rom_bhe_n), .rom_ble_n(rom_ble_n), .rom_we_n(rom_we_n),
    .rom_wdata(rom_wdata), .rom_wdata_oe(rom_wdata_oe), .rom_rdata(rom_rdata)
  );

  // --------------------------------------------------
  // clocks and memory model
  // --------------------------------------------------

  initial begin
    CLK2 = 1'b0;
    forever #10 CLK2 = ~CLK2;
  end

  // console CPU clock is held low while the console is stopped
  initial begin
    int   phase;
    logic run;
    phase = 0;
    snes_cpu_clk = 1'b0;
    forever begin
      @(posedge CLK2);
      run = console_run;
      #2;
      if (run) begin
        phase++;
        if (phase == console_half) begin
          snes_cpu_clk = ~snes_cpu_clk;
          phase = 0;
        end
      end else begin
        snes_cpu_clk = 1'b0;
        phase = 0;
      end
    end
  end

  // even byte on the high lane and odd byte on the low lane
  assign rom_rdata = mem[rom_addr[10:0]];

  always @(posedge CLK2) begin
    if (!rom_we_n) begin
      if (!rom_bhe_n) mem[rom_addr[10:0]][15:8] <= rom_wdata[15:8];
      if (!rom_ble_n) mem[rom_addr[10:0]][7:0] <= rom_wdata[7:0];
      last_wr_addr <= {rom_addr, rom_bhe_n};
    end
  end

  // the memory drives the data bus whenever the controller does not write
  always @(posedge CLK2) begin
    if (!reset && rom_wdata_oe !== !rom_we_n) begin
      $display("error at %0t: rom_wdata_oe is %b while rom_we_n is %b",
               $time, rom_wdata_oe, rom_we_n);
      fail_run();
    end
  end

  always @(posedge CLK2) begin
    if (!reset && sa1_reset) restart_pulses++;
  end

  // --------------------------------------------------
  // models and helpers
  // --------------------------------------------------

  function automatic byte_t fill_byte(int a);
    logic [11:0] b;
    b = a[11:0];
    return b[7:0] ^ {b[11:8], b[11:8]} ^ 8'h5a;
  endfunction

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected read data with the byte at the address in bits 7..0
  function automatic rom_word_t ref_read(snes_addr_t a, logic word);
    int i;
    i = int'(a[11:0]);
    if (word) return {shadow[i + 1], shadow[i]};
    else return {8'h00, shadow[i]};
  endfunction

  task automatic wait_cycle();
    @(posedge CLK2);
    #2;
  endtask

  task automatic fail_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_byte(byte_t exp, byte_t act, string what);
    if (act !== exp) begin
      err_count++;
      $display("error at %0t: %s, expected %h, got %h", $time, what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_word(rom_word_t exp, rom_word_t act, string what);
    if (act !== exp) begin
      err_count++;
      $display("error at %0t: %s, expected %h, got %h", $time, what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_addr(snes_addr_t exp, snes_addr_t act, string what);
    if (act !== exp) begin
      err_count++;
      $display("error at %0t: %s, expected %h, got %h", $time, what, exp, act);
      fail_run();
    end
  endtask

  task automatic push_result(int kind, logic [23:0] exp, logic [23:0] act, string what);
    result_t r;
    r.kind = kind;
    r.exp  = exp;
    r.act  = act;
    r.what = what;
    results.push_back(r);
    n_pushed++;
  endtask

  // --------------------------------------------------
  // request tasks
  // --------------------------------------------------

  task automatic mcu_write(snes_addr_t a, byte_t d);
    mcu_addr  = a;
    mcu_wdata = d;
    mcu_wrq   = 1'b1;
    wait_cycle();
    mcu_wrq = 1'b0;
    while (!mcu_rdy) wait_cycle();
    shadow[a[11:0]] = d;
    push_result(kind_addr, a, last_wr_addr, $sformatf("mcu write address %h", a));
  endtask

  task automatic mcu_read(snes_addr_t a);
    rom_word_t exp;
    mcu_addr = a;
    mcu_rrq  = 1'b1;
    wait_cycle();
    mcu_rrq = 1'b0;
    while (!mcu_rdy) wait_cycle();
    exp = ref_read(a, 1'b0);
    push_result(kind_byte, exp[7:0], mcu_rdata, $sformatf("mcu read at %h", a));
  endtask

  task automatic sa1_write(snes_addr_t a, rom_word_t w);
    int i;
    i = int'(a[11:0]);
    sa1_addr  = a;
    sa1_word  = 1'b1;
    sa1_wdata = w;
    sa1_wrq   = 1'b1;
    wait_cycle();
    sa1_wrq = 1'b0;
    while (!sa1_rdy) wait_cycle();
    shadow[i]     = w[7:0];
    shadow[i + 1] = w[15:8];
    push_result(kind_addr, a, last_wr_addr, $sformatf("sa1 write address %h", a));
  endtask

  task automatic sa1_read(snes_addr_t a, logic word);
    rom_word_t exp;
    sa1_addr = a;
    sa1_word = word;
    sa1_rrq  = 1'b1;
    wait_cycle();
    sa1_rrq = 1'b0;
    while (!sa1_rdy) wait_cycle();
    exp = ref_read(a, word);
    if (word) push_result(kind_word, exp, sa1_rdata, $sformatf("sa1 word read at %h", a));
    else push_result(kind_byte, exp[7:0], sa1_rdata[7:0], $sformatf("sa1 byte read at %h", a));
  endtask

  // --------------------------------------------------
  // comparison
  // --------------------------------------------------

  initial begin
    result_t r;
    forever begin
      wait (n_pushed > n_checked);
      r = results.pop_front();
      case (r.kind)
        kind_byte: check_byte(byte_t'(r.exp), byte_t'(r.act), r.what);
        kind_word: check_word(rom_word_t'(r.exp), rom_word_t'(r.act), r.what);
        default:   check_addr(snes_addr_t'(r.exp), snes_addr_t'(r.act), r.what);
      endcase
      n_checked++;
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    snes_addr_t addrs [$];
    snes_addr_t a;
    snes_addr_t b;
    int         sa1_at;
    int         mcu_at;
    int         n;
    int         base;
    reset = 1'b1;
    snes_addr = '0;
    snes_rd_n = 1'b1;
    snes_romsel_n = 1'b1;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    sa1_rrq = 1'b0;
    sa1_wrq = 1'b0;
    sa1_addr = '0;
    sa1_word = 1'b0;
    sa1_wdata = '0;
    console_run = 1'b0;
    lcg_state = 32'h6762;
    n_pushed = 0;
    n_checked = 0;
    err_count = 0;
    restart_pulses = 0;
    for (int w = 0; w < 2048; w++) begin
      mem[w] = {fill_byte(2 * w), fill_byte(2 * w + 1)};
    end
    for (int i = 0; i < 4096; i++) begin
      shadow[i] = fill_byte(i);
    end
    repeat (16) wait_cycle();
    reset = 1'b0;
    wait_cycle();

    // MCU byte traffic while the console is dead
    for (int i = 0; i < n_mcu; i++) begin
      a = snes_addr_t'(next_rand() >> 16) & 24'hfff;
      addrs.push_back(a);
      mcu_write(a, byte_t'(next_rand() >> 20));
    end
    foreach (addrs[i]) mcu_read(addrs[i]);

    // SA1 words at even addresses and then byte reads
    addrs.delete();
    for (int i = 0; i < n_sa1; i++) begin
      a = snes_addr_t'(next_rand() >> 16) & 24'hffe;
      addrs.push_back(a);
      sa1_write(a, rom_word_t'(next_rand() >> 12));
    end
    foreach (addrs[i]) sa1_read(addrs[i], 1'b1);
    for (int i = 0; i < n_sa1; i++) begin
      sa1_read(snes_addr_t'(next_rand() >> 16) & 24'hfff, 1'b0);
    end

    // SA1 and MCU strobe together and SA1 wins
    for (int i = 0; i < n_both; i++) begin
      a = snes_addr_t'(next_rand() >> 16) & 24'hffe;
      b = snes_addr_t'(next_rand() >> 16) & 24'hfff;
      sa1_addr = a;
      sa1_word = 1'b1;
      sa1_rrq  = 1'b1;
      mcu_addr = b;
      mcu_rrq  = 1'b1;
      wait_cycle();
      sa1_rrq = 1'b0;
      mcu_rrq = 1'b0;
      sa1_at = -1;
      mcu_at = -1;
      n = 0;
      while (sa1_at < 0 || mcu_at < 0) begin
        if (sa1_rdy && sa1_at < 0) sa1_at = n;
        if (mcu_rdy && mcu_at < 0) mcu_at = n;
        wait_cycle();
        n++;
      end
      if (sa1_at >= mcu_at) begin
        $display("the MCU read finished before the SA1 read that was granted first");
        fail_run();
      end
      push_result(kind_word, ref_read(a, 1'b1), sa1_rdata, $sformatf("joint sa1 read %h", a));
      push_result(kind_byte, shadow[b[11:0]], mcu_rdata, $sformatf("joint mcu read %h", b));
    end

    // live console reading ROM
    base = restart_pulses;
    snes_romsel_n = 1'b0;
    snes_rd_n = 1'b0;
    console_run = 1'b1;
    repeat (40) wait_cycle();
    push_result(kind_byte, 1, restart_pulses - base, "restart pulses at console start");
    for (int i = 0; i < n_console_reads; i++) begin
      a = snes_addr_t'(next_rand() >> 16) & 24'hfff;
      snes_addr = a;
      repeat (16) wait_cycle();
      push_result(kind_byte, shadow[a[11:0]], snes_rdata, $sformatf("console read at %h", a));
    end
    for (int i = 0; i < n_live; i++) begin
      a = snes_addr_t'(next_rand() >> 16) & 24'hfff;
      mcu_write(a, byte_t'(next_rand() >> 20));
      mcu_read(a);
    end

    // stall past the dead timeout and resume
    base = restart_pulses;
    console_run = 1'b0;
    repeat (dead_timeout + 100) wait_cycle();
    console_run = 1'b1;
    repeat (60) wait_cycle();
    push_result(kind_byte, 1, restart_pulses - base, "restart pulses after a stall");

    wait (n_checked == n_pushed);
    if (err_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      fail_run();
    end
  end

  // watchdog
  initial begin
    repeat (timeout_cycles) @(posedge CLK2);
    $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    fail_run();
  end

endmodule

/* rtl/rom_arb_pkg.sv */
package rom_arb_pkg;

  // ---------------------------------------------
  // address and data widths
  // ---------------------------------------------

  // console or requester byte address
  typedef logic [23:0] snes_addr_t;

  // ROM word address, byte address without bit 0
  typedef logic [22:0] rom_word_addr_t;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;

  // ---------------------------------------------
  // counters
  // ---------------------------------------------

  // access length down counter
  typedef logic [3:0]  cycle_cnt_t;

  // time since the console clock was last seen high
  typedef logic [17:0] dead_cnt_t;

  // ---------------------------------------------
  // arbiter states
  // ---------------------------------------------

  typedef enum logic [3:0] {
    st_idle,
    st_mcu_rd,
    st_mcu_rd_end,
    st_mcu_wr,
    st_mcu_wr_end,
    st_sa1_rd,
    st_sa1_rd_end,
    st_sa1_wr,
    st_sa1_wr_end
  } arb_state_t;

  // sampling stages for the console signals
  localparam int sync_depth = 8;

endpackage

/* rtl/rom_arbiter.sv */
`timescale 1ns/10ps

module rom_arbiter #(
  parameter int rom_cycle_len = 7
) (
  input  logic                    CLK2,
  input  logic                    reset,
  input  logic                    free_slot,
  input  logic                    snes_dead,
  input  logic                    alive_edge,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  rom_arb_pkg::snes_addr_t mcu_addr,
  input  rom_arb_pkg::byte_t      mcu_wdata,
  input  logic                    sa1_rrq,
  input  logic                    sa1_wrq,
  input  rom_arb_pkg::snes_addr_t sa1_addr,
  input  logic                    sa1_word,
  input  rom_arb_pkg::rom_word_t  sa1_wdata,
  output rom_arb_pkg::arb_state_t state,
  output rom_arb_pkg::snes_addr_t mcu_addr_q,
  output rom_arb_pkg::byte_t      mcu_wdata_q,
  output rom_arb_pkg::snes_addr_t sa1_addr_q,
  output logic                    sa1_word_q,
  output rom_arb_pkg::rom_word_t  sa1_wdata_q,
  output logic                    mcu_rdy,
  output logic                    sa1_rdy
);

  import rom_arb_pkg::*;

  cycle_cnt_t cnt;
  logic       mcu_rd_pend;
  logic       mcu_wr_pend;
  logic       sa1_rd_pend;
  logic       sa1_wr_pend;
  logic       sa1_access;

  // access state to its end state
  function automatic arb_state_t end_of(arb_state_t s);
    case (s)
      st_mcu_rd: end_of = st_mcu_rd_end;
      st_mcu_wr: end_of = st_mcu_wr_end;
      st_sa1_rd: end_of = st_sa1_rd_end;
      default:   end_of = st_sa1_wr_end;
    endcase
  endfunction

  assign sa1_access = (state == st_sa1_rd) || (state == st_sa1_wr);

  // --------------------------------------------------
  // MCU request bookkeeping
  // --------------------------------------------------

  always_ff @(posedge CLK2) begin
    if (reset) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rd_pend <= 1'b0;
      mcu_rdy     <= 1'b0;
    end else if (state == st_mcu_rd_end || state == st_mcu_wr_end) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) begin
      mcu_addr_q  <= mcu_addr;
      mcu_wdata_q <= mcu_wdata;
    end
  end

  // --------------------------------------------------
  // SA1 request bookkeeping
  // --------------------------------------------------

  always_ff @(posedge CLK2) begin
    if (reset) begin
      sa1_rd_pend <= 1'b0;
      sa1_wr_pend <= 1'b0;
      sa1_rdy     <= 1'b1;
    end else if (sa1_rrq) begin
      sa1_rd_pend <= 1'b1;
      sa1_wr_pend <= 1'b0;
      sa1_rdy     <= 1'b0;
    end else if (sa1_wrq) begin
      sa1_wr_pend <= 1'b1;
      sa1_rd_pend <= 1'b0;
      sa1_rdy     <= 1'b0;
    end else if (sa1_access && cnt == '0) begin
      // ready one cycle early, data is already captured
      sa1_rdy <= 1'b1;
    end else if (state == st_sa1_rd_end || state == st_sa1_wr_end) begin
      sa1_rd_pend <= 1'b0;
      sa1_wr_pend <= 1'b0;
      sa1_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (sa1_rrq || sa1_wrq) begin
      sa1_addr_q <= sa1_addr;
      sa1_word_q <= sa1_word;
    end
    if (sa1_wrq) begin
      sa1_wdata_q <= sa1_wdata;
    end
  end

  // --------------------------------------------------
  // arbitration
  // --------------------------------------------------

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else if (alive_edge) begin
      // pending flags stay set, so the access is granted again
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (free_slot || snes_dead) begin
            // SA1 read strobe is taken in the same cycle
            if (sa1_rd_pend || sa1_rrq) begin
              state <= st_sa1_rd;
              cnt   <= cycle_cnt_t'(rom_cycle_len);
            end else if (sa1_wr_pend) begin
              state <= st_sa1_wr;
              cnt   <= cycle_cnt_t'(rom_cycle_len);
            end else if (mcu_rd_pend) begin
              state <= st_mcu_rd;
              cnt   <= cycle_cnt_t'(rom_cycle_len);
            end else if (mcu_wr_pend) begin
              state <= st_mcu_wr;
              cnt   <= cycle_cnt_t'(rom_cycle_len);
            end
          end
        end
        st_mcu_rd, st_mcu_wr, st_sa1_rd, st_sa1_wr: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            state <= end_of(state);
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

/* rtl/rom_ctrl_top.sv */
`timescale 1ns/10ps

module rom_ctrl_top #(
  parameter int rom_cycle_len = 7,
  parameter int dead_timeout  = 96000
) (
  input  logic                        CLK2,
  input  logic                        reset,
  // console bus
  input  rom_arb_pkg::snes_addr_t     snes_addr,
  input  logic                        snes_rd_n,
  input  logic                        snes_romsel_n,
  input  logic                        snes_cpu_clk,
  output rom_arb_pkg::byte_t          snes_rdata,
  // MCU port
  input  logic                        mcu_rrq,
  input  logic                        mcu_wrq,
  input  rom_arb_pkg::snes_addr_t     mcu_addr,
  input  rom_arb_pkg::byte_t          mcu_wdata,
  output logic                        mcu_rdy,
  output rom_arb_pkg::byte_t          mcu_rdata,
  // SA1 port
  input  logic                        sa1_rrq,
  input  logic                        sa1_wrq,
  input  rom_arb_pkg::snes_addr_t     sa1_addr,
  input  logic                        sa1_word,
  input  rom_arb_pkg::rom_word_t      sa1_wdata,
  output logic                        sa1_rdy,
  output rom_arb_pkg::rom_word_t      sa1_rdata,
  output logic                        sa1_reset,
  // ROM pins
  output rom_arb_pkg::rom_word_addr_t rom_addr,
  output logic                        rom_bhe_n,
  output logic                        rom_ble_n,
  output logic                        rom_we_n,
  output rom_arb_pkg::rom_word_t      rom_wdata,
  output logic                        rom_wdata_oe,
  input  rom_arb_pkg::rom_word_t      rom_rdata
);

  import rom_arb_pkg::*;

  snes_addr_t snes_addr_s;
  logic       snes_rd_s;
  logic       snes_romsel_s;
  logic       free_slot;
  logic       snes_dead;
  logic       alive_edge;
  arb_state_t state;
  snes_addr_t mcu_addr_q;
  byte_t      mcu_wdata_q;
  snes_addr_t sa1_addr_q;
  logic       sa1_word_q;
  rom_word_t  sa1_wdata_q;

  snes_bus_sync #(
    .dead_timeout(dead_timeout)
  ) i_bus_sync (
    .CLK2(CLK2),
    .reset(reset),
    .snes_addr(snes_addr),
    .snes_rd_n(snes_rd_n),
    .snes_romsel_n(snes_romsel_n),
    .snes_cpu_clk(snes_cpu_clk),
    .snes_addr_s(snes_addr_s),
    .snes_rd_s(snes_rd_s),
    .snes_romsel_s(snes_romsel_s),
    .snes_cycle_start(),
    .snes_cycle_end(),
    .free_slot(free_slot),
    .snes_dead(snes_dead),
    .restart(sa1_reset),
    .alive_edge(alive_edge)
  );

  rom_arbiter #(
    .rom_cycle_len(rom_cycle_len)
  ) i_arbiter (
    .CLK2(CLK2),
    .reset(reset),
    .free_slot(free_slot),
    .snes_dead(snes_dead),
    .alive_edge(alive_edge),
    .mcu_rrq(mcu_rrq),
    .mcu_wrq(mcu_wrq),
    .mcu_addr(mcu_addr),
    .mcu_wdata(mcu_wdata),
    .sa1_rrq(sa1_rrq),
    .sa1_wrq(sa1_wrq),
    .sa1_addr(sa1_addr),
    .sa1_word(sa1_word),
    .sa1_wdata(sa1_wdata),
    .state(state),
    .mcu_addr_q(mcu_addr_q),
    .mcu_wdata_q(mcu_wdata_q),
    .sa1_addr_q(sa1_addr_q),
    .sa1_word_q(sa1_word_q),
    .sa1_wdata_q(sa1_wdata_q),
    .mcu_rdy(mcu_rdy),
    .sa1_rdy(sa1_rdy)
  );

  rom_port i_rom_port (
    .CLK2(CLK2),
    .reset(reset),
    .state(state),
    .snes_addr_s(snes_addr_s),
    .snes_romsel_s(snes_romsel_s),
    .snes_rd_s(snes_rd_s),
    .mcu_addr_q(mcu_addr_q),
    .mcu_wdata_q(mcu_wdata_q),
    .sa1_addr_q(sa1_addr_q),
    .sa1_word_q(sa1_word_q),
    .sa1_wdata_q(sa1_wdata_q),
    .rom_rdata(rom_rdata),
    .rom_addr(rom_addr),
    .rom_bhe_n(rom_bhe_n),
    .rom_ble_n(rom_ble_n),
    .rom_we_n(rom_we_n),
    .rom_wdata(rom_wdata),
    .rom_wdata_oe(rom_wdata_oe),
    .mcu_rdata(mcu_rdata),
    .sa1_rdata(sa1_rdata),
    .snes_rdata(snes_rdata)
  );

endmodule

/* rtl/rom_port.sv */
`timescale 1ns/10ps

module rom_port (
  input  logic                        CLK2,
  input  logic                        reset,
  input  rom_arb_pkg::arb_state_t     state,
  input  rom_arb_pkg::snes_addr_t     snes_addr_s,
  input  logic                        snes_romsel_s,
  input  logic                        snes_rd_s,
  input  rom_arb_pkg::snes_addr_t     mcu_addr_q,
  input  rom_arb_pkg::byte_t          mcu_wdata_q,
  input  rom_arb_pkg::snes_addr_t     sa1_addr_q,
  input  logic                        sa1_word_q,
  input  rom_arb_pkg::rom_word_t      sa1_wdata_q,
  input  rom_arb_pkg::rom_word_t      rom_rdata,
  output rom_arb_pkg::rom_word_addr_t rom_addr,
  output logic                        rom_bhe_n,
  output logic                        rom_ble_n,
  output logic                        rom_we_n,
  output rom_arb_pkg::rom_word_t      rom_wdata,
  output logic                        rom_wdata_oe,
  output rom_arb_pkg::byte_t          mcu_rdata,
  output rom_arb_pkg::rom_word_t      sa1_rdata,
  output rom_arb_pkg::byte_t          snes_rdata
);

  import rom_arb_pkg::*;

  snes_addr_t sel_addr;
  logic       addr0;
  logic       addr0_q;
  logic       sa1_hit;
  logic       mcu_hit;
  logic       word_en;
  byte_t      lane_byte;

  // --------------------------------------------------
  // address and lanes
  // --------------------------------------------------

  assign sa1_hit = (state == st_sa1_rd) || (state == st_sa1_wr);
  assign mcu_hit = (state == st_mcu_rd) || (state == st_mcu_wr);

  assign sel_addr = sa1_hit ? sa1_addr_q :
                    mcu_hit ? mcu_addr_q :
                              snes_addr_s;

  assign rom_addr = sel_addr[23:1];
  assign addr0    = sel_addr[0];

  // odd bytes sit in the low lane
  assign word_en   = sa1_hit & sa1_word_q;
  assign rom_bhe_n = addr0 & ~word_en;
  assign rom_ble_n = ~addr0 & ~word_en;

  // --------------------------------------------------
  // write path
  // --------------------------------------------------

  assign rom_we_n     = ~((state == st_mcu_wr) || (state == st_sa1_wr));
  assign rom_wdata_oe = ~rom_we_n;

  // even address puts the first byte on the high lane
  always_comb begin
    if (state == st_sa1_wr) begin
      rom_wdata = addr0 ? sa1_wdata_q : {sa1_wdata_q[7:0], sa1_wdata_q[15:8]};
    end else if (state == st_mcu_wr) begin
      rom_wdata = {mcu_wdata_q, mcu_wdata_q};
    end else begin
      rom_wdata = '0;
    end
  end

  // --------------------------------------------------
  // read capture
  // --------------------------------------------------

  assign lane_byte = addr0 ? rom_rdata[7:0] : rom_rdata[15:8];

  always_ff @(posedge CLK2) begin
    if (reset) begin
      addr0_q <= 1'b0;
    end else begin
      addr0_q <= addr0;
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == st_mcu_rd) begin
      mcu_rdata <= lane_byte;
    end
    // word read, byte at the address lands in bits 7..0
    if (state == st_sa1_rd) begin
      sa1_rdata <= addr0_q ? rom_rdata : {rom_rdata[7:0], rom_rdata[15:8]};
    end
  end

  // console read, only while the console owns the address
  always_ff @(posedge CLK2) begin
    if (state == st_idle && !snes_rd_s && !snes_romsel_s) begin
      snes_rdata <= lane_byte;
    end
  end

endmodule

/* rtl/snes_bus_sync.sv */
`timescale 1ns/10ps

module snes_bus_sync #(
  parameter int dead_timeout = 96000
) (
  input  logic                    CLK2,
  input  logic                    reset,
  input  rom_arb_pkg::snes_addr_t snes_addr,
  input  logic                    snes_rd_n,
  input  logic                    snes_romsel_n,
  input  logic                    snes_cpu_clk,
  output rom_arb_pkg::snes_addr_t snes_addr_s,
  output logic                    snes_rd_s,
  output logic                    snes_romsel_s,
  output logic                    snes_cycle_start,
  output logic                    snes_cycle_end,
  output logic                    free_slot,
  output logic                    snes_dead,
  output logic                    restart,
  output logic                    alive_edge
);

  import rom_arb_pkg::*;

  // filter tap, levels are the AND of two neighbouring samples
  localparam int tap = 4;

  // clock history patterns, newest samples in the low bits
  localparam logic [sync_depth-3:0] start_pat = 6'b000011;
  localparam logic [sync_depth-3:0] end_pat   = 6'b111000;

  logic [sync_depth-1:0] rd_sr;
  logic [sync_depth-1:0] romsel_sr;
  logic [sync_depth-1:0] clk_sr;
  snes_addr_t            addr_sr [0:sync_depth-2];
  dead_cnt_t             dead_cnt;
  logic                  free_strobe;
  logic                  clk_now;

  // --------------------------------------------------
  // sampling
  // --------------------------------------------------

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_sr     <= '1;
      romsel_sr <= '1;
      clk_sr    <= '0;
    end else begin
      rd_sr     <= {rd_sr[sync_depth-2:0], snes_rd_n};
      romsel_sr <= {romsel_sr[sync_depth-2:0], snes_romsel_n};
      clk_sr    <= {clk_sr[sync_depth-2:0], snes_cpu_clk};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr;
    for (int i = 1; i < sync_depth - 1; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  always_ff @(posedge CLK2) begin
    snes_addr_s <= addr_sr[tap] & addr_sr[tap-1];
  end

  // levels and cycle edges
  always_ff @(posedge CLK2) begin
    if (reset) begin
      snes_rd_s        <= 1'b1;
      snes_romsel_s    <= 1'b1;
      snes_cycle_start <= 1'b0;
      snes_cycle_end   <= 1'b0;
    end else begin
      snes_rd_s        <= rd_sr[tap] & rd_sr[tap-1];
      snes_romsel_s    <= romsel_sr[tap] & romsel_sr[tap-1];
      snes_cycle_start <= (clk_sr[sync_depth-1:2] & clk_sr[sync_depth-2:1]) == start_pat;
      snes_cycle_end   <= (clk_sr[sync_depth-1:2] | clk_sr[sync_depth-2:1]) == end_pat;
    end
  end

  // --------------------------------------------------
  // free slot
  // --------------------------------------------------

  // whole console cycle is free when it does not touch ROM
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else if (snes_cycle_start) begin
      free_strobe <= snes_romsel_s;
    end else if (snes_cycle_end) begin
      free_strobe <= 1'b0;
    end
  end

  assign free_slot = free_strobe | snes_cycle_end;

  // --------------------------------------------------
  // dead console detection
  // --------------------------------------------------

  assign clk_now = clk_sr[1];

  always_ff @(posedge CLK2) begin
    if (reset || clk_now) begin
      dead_cnt <= '0;
    end else if (dead_cnt != '1) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      snes_dead <= 1'b1;
      restart   <= 1'b0;
    end else begin
      restart <= 1'b0;
      if (clk_now) begin
        snes_dead <= 1'b0;
        restart   <= snes_dead;
      end else if (dead_cnt > dead_cnt_t'(dead_timeout)) begin
        snes_dead <= 1'b1;
      end
    end
  end

  // console wakes up, abort whatever runs on the ROM
  assign alive_edge = snes_dead & clk_now;

endmodule
